// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing -j 0
TOP = BattleTopTb
FILELIST = list.f
BUILD_DIR = obj_dir

.PHONY: all build lint clean

# Build, then run; a $fatal in the testbench gives a failing exit status
all: build
	./$(BUILD_DIR)/V$(TOP)

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: list.f
+incdir+src
src/battlePkg.sv
src/StepSequencer.sv
src/FrontScan.sv
src/DamageTotals.sv
src/ArmyRoster.sv
src/BattleTop.sv
tests/BattleTopTb.sv

// File: src/ArmyRoster.sv
`include "battle_settings.svh"

module ArmyRoster #(
	parameter bit Forward = 1'b1
) (
	input logic ClkPort,
	input logic Reset,
	input logic applyEn,
	input logic spawn,
	input battlePkg::fighterKindT spawnKind,
	input battlePkg::frontT ownFront,
	input battlePkg::damageT incomingDamage,
	output battlePkg::armyT army,
	output battlePkg::slotMaskT alive,
	output battlePkg::scoreT losses
);

	localparam battlePkg::positionT FieldEnd = battlePkg::positionT'(`FIELD_END);

	// Friendly side enters at 0, enemy side at the far end
	localparam battlePkg::positionT SpawnPosition =
		Forward ? battlePkg::positionT'(0) : FieldEnd;

	battlePkg::fighterKindT kindQ [`SLOT_COUNT];
	battlePkg::positionT positionQ [`SLOT_COUNT];
	battlePkg::healthT healthQ [`SLOT_COUNT];

	battlePkg::slotMaskT freeMask;
	battlePkg::slotMaskT grantMask;
	logic spawnTake;
	logic frontHit;
	logic frontDies;

	// One step along the lane, clamped at either end
	function automatic battlePkg::positionT advance(input battlePkg::positionT pos,
			input battlePkg::fighterKindT kind);
		battlePkg::positionT speed;
		speed = battlePkg::kindSpeed(kind);
		if (Forward) begin
			return (pos >= FieldEnd - speed) ? FieldEnd : pos + speed;
		end
		return (pos <= speed) ? battlePkg::positionT'(0) : pos - speed;
	endfunction

	always_comb begin
		freeMask = ~alive;
		// Lowest free slot wins
		grantMask = freeMask & (~freeMask + battlePkg::slotMaskT'(1));
		spawnTake = spawn && !applyEn && (|freeMask);

		frontHit = applyEn && ownFront.frontValid && alive[ownFront.frontSlot];
		frontDies = frontHit &&
			(battlePkg::damageT'(healthQ[ownFront.frontSlot]) <= incomingDamage);
	end

	always_ff @(posedge ClkPort or posedge Reset) begin
		if (Reset) begin
			alive <= '0;
			losses <= '0;
		end else if (spawnTake) begin
			alive <= alive | grantMask;
		end else if (frontDies) begin
			alive[ownFront.frontSlot] <= 1'b0;
			losses <= losses + battlePkg::scoreT'(1);
		end
	end

	always_ff @(posedge ClkPort) begin
		for (int i = 0; i < `SLOT_COUNT; i++) begin
			if (spawnTake && grantMask[i]) begin
				kindQ[i] <= spawnKind;
				positionQ[i] <= SpawnPosition;
				healthQ[i] <= battlePkg::kindHealth(spawnKind);
			end else if (applyEn && alive[i]) begin
				// Engaged fighters hold their ground
				if (!ownFront.engaged[i]) begin
					positionQ[i] <= advance(positionQ[i], kindQ[i]);
				end
				if (frontHit && !frontDies &&
						ownFront.frontSlot == battlePkg::slotIndexT'(i)) begin
					healthQ[i] <= healthQ[i] - battlePkg::healthT'(incomingDamage);
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `SLOT_COUNT; i++) begin
			army[i].alive = alive[i];
			army[i].kind = kindQ[i];
			army[i].position = positionQ[i];
			army[i].health = healthQ[i];
		end
	end

endmodule

// File: src/BattleTop.sv
module BattleTop (
	input logic ClkPort,
	input logic Reset,
	input logic Tick,
	input logic SpawnUnit,
	input battlePkg::fighterKindT SpawnUnitKind,
	input logic SpawnEnemy,
	input battlePkg::fighterKindT SpawnEnemyKind,
	output battlePkg::scoreT Score,
	output battlePkg::scoreT UnitLosses,
	output battlePkg::positionT FriendlyFront,
	output battlePkg::positionT EnemyFront,
	output battlePkg::slotMaskT UnitAlive,
	output battlePkg::slotMaskT EnemyAlive,
	output logic StepDone
);

	logic scanEn;
	logic totalEn;
	logic applyEn;

	battlePkg::armyT friendlyArmy;
	battlePkg::armyT enemyArmy;
	battlePkg::frontT friendlyFront;
	battlePkg::frontT enemyFront;
	battlePkg::damageT unitDamage;
	battlePkg::damageT enemyDamage;

	StepSequencer sequencer (
		.ClkPort(ClkPort),
		.Reset(Reset),
		.Tick(Tick),
		.scanEn(scanEn),
		.totalEn(totalEn),
		.applyEn(applyEn),
		.StepDone(StepDone)
	);

	FrontScan frontScan (
		.ClkPort(ClkPort),
		.Reset(Reset),
		.scanEn(scanEn),
		.friendlyArmy(friendlyArmy),
		.enemyArmy(enemyArmy),
		.friendlyFront(friendlyFront),
		.enemyFront(enemyFront)
	);

	DamageTotals damageTotals (
		.ClkPort(ClkPort),
		.Reset(Reset),
		.totalEn(totalEn),
		.friendlyArmy(friendlyArmy),
		.enemyArmy(enemyArmy),
		.friendlyFront(friendlyFront),
		.enemyFront(enemyFront),
		.unitDamage(unitDamage),
		.enemyDamage(enemyDamage)
	);

	// Each side takes the other side's total on its front
	ArmyRoster #(.Forward(1'b1)) friendlyRoster (
		.ClkPort(ClkPort),
		.Reset(Reset),
		.applyEn(applyEn),
		.spawn(SpawnUnit),
		.spawnKind(SpawnUnitKind),
		.ownFront(friendlyFront),
		.incomingDamage(enemyDamage),
		.army(friendlyArmy),
		.alive(UnitAlive),
		.losses(UnitLosses)
	);

	ArmyRoster #(.Forward(1'b0)) enemyRoster (
		.ClkPort(ClkPort),
		.Reset(Reset),
		.applyEn(applyEn),
		.spawn(SpawnEnemy),
		.spawnKind(SpawnEnemyKind),
		.ownFront(enemyFront),
		.incomingDamage(unitDamage),
		.army(enemyArmy),
		.alive(EnemyAlive),
		.losses(Score)
	);

	// Scan registers, so these lag the rosters by one step
	assign FriendlyFront = friendlyFront.frontPosition;
	assign EnemyFront = enemyFront.frontPosition;

endmodule

// File: src/DamageTotals.sv
`include "battle_settings.svh"

module DamageTotals (
	input logic ClkPort,
	input logic Reset,
	input logic totalEn,
	input battlePkg::armyT friendlyArmy,
	input battlePkg::armyT enemyArmy,
	input battlePkg::frontT friendlyFront,
	input battlePkg::frontT enemyFront,
	output battlePkg::damageT unitDamage,
	output battlePkg::damageT enemyDamage
);

	battlePkg::damageT unitSum;
	battlePkg::damageT enemySum;

	// Engaged masks were taken at scan, slots cannot die before apply
	always_comb begin
		unitSum = '0;
		enemySum = '0;
		for (int i = 0; i < `SLOT_COUNT; i++) begin
			if (friendlyFront.engaged[i]) begin
				unitSum = unitSum +
					battlePkg::damageT'(battlePkg::kindAttack(friendlyArmy[i].kind));
			end
			if (enemyFront.engaged[i]) begin
				enemySum = enemySum +
					battlePkg::damageT'(battlePkg::kindAttack(enemyArmy[i].kind));
			end
		end
	end

	always_ff @(posedge ClkPort or posedge Reset) begin
		if (Reset) begin
			unitDamage <= '0;
			enemyDamage <= '0;
		end else if (totalEn) begin
			unitDamage <= unitSum;
			enemyDamage <= enemySum;
		end
	end

endmodule

// File: src/FrontScan.sv
`include "battle_settings.svh"

module FrontScan (
	input logic ClkPort,
	input logic Reset,
	input logic scanEn,
	input battlePkg::armyT friendlyArmy,
	input battlePkg::armyT enemyArmy,
	output battlePkg::frontT friendlyFront,
	output battlePkg::frontT enemyFront
);

	localparam battlePkg::positionT FieldEnd = battlePkg::positionT'(`FIELD_END);
	localparam battlePkg::positionT Range = battlePkg::positionT'(`ATTACK_RANGE);

	// Empty sides read 0 and FIELD_END
	localparam battlePkg::frontT FriendlyEmpty = '0;
	localparam battlePkg::frontT EnemyEmpty = '{
		frontPosition: FieldEnd,
		frontSlot: '0,
		frontValid: 1'b0,
		engaged: '0
	};

	battlePkg::frontT friendlyNext;
	battlePkg::frontT enemyNext;

	always_comb begin
		friendlyNext = FriendlyEmpty;
		enemyNext = EnemyEmpty;

		// Strict compares keep the lowest slot on a tie
		for (int i = 0; i < `SLOT_COUNT; i++) begin
			if (friendlyArmy[i].alive && (!friendlyNext.frontValid ||
					friendlyArmy[i].position > friendlyNext.frontPosition)) begin
				friendlyNext.frontValid = 1'b1;
				friendlyNext.frontPosition = friendlyArmy[i].position;
				friendlyNext.frontSlot = battlePkg::slotIndexT'(i);
			end
			if (enemyArmy[i].alive && (!enemyNext.frontValid ||
					enemyArmy[i].position < enemyNext.frontPosition)) begin
				enemyNext.frontValid = 1'b1;
				enemyNext.frontPosition = enemyArmy[i].position;
				enemyNext.frontSlot = battlePkg::slotIndexT'(i);
			end
		end

		// Range check against the opposing front
		for (int i = 0; i < `SLOT_COUNT; i++) begin
			friendlyNext.engaged[i] = friendlyArmy[i].alive && enemyNext.frontValid &&
				(enemyNext.frontPosition <= friendlyArmy[i].position + Range);
			enemyNext.engaged[i] = enemyArmy[i].alive && friendlyNext.frontValid &&
				(enemyArmy[i].position <= friendlyNext.frontPosition + Range);
		end
	end

	always_ff @(posedge ClkPort or posedge Reset) begin
		if (Reset) begin
			friendlyFront <= FriendlyEmpty;
			enemyFront <= EnemyEmpty;
		end else if (scanEn) begin
			friendlyFront <= friendlyNext;
			enemyFront <= enemyNext;
		end
	end

endmodule

// File: src/StepSequencer.sv
module StepSequencer (
	input logic ClkPort,
	input logic Reset,
	input logic Tick,
	output logic scanEn,
	output logic totalEn,
	output logic applyEn,
	output logic StepDone
);

	battlePkg::stepStateT state;
	battlePkg::stepStateT nextState;

	always_ff @(posedge ClkPort or posedge Reset) begin
		if (Reset) begin
			state <= battlePkg::Idle;
		end else begin
			state <= nextState;
		end
	end

	// One cycle per stage, Tick only counts in Idle
	always_comb begin
		nextState = state;
		case (state)
			battlePkg::Idle: begin
				if (Tick) begin
					nextState = battlePkg::Scan;
				end
			end
			battlePkg::Scan: begin
				nextState = battlePkg::Total;
			end
			battlePkg::Total: begin
				nextState = battlePkg::Apply;
			end
			battlePkg::Apply: begin
				nextState = battlePkg::Done;
			end
			default: begin
				nextState = battlePkg::Idle;
			end
		endcase
	end

	assign scanEn = (state == battlePkg::Scan);
	assign totalEn = (state == battlePkg::Total);
	assign applyEn = (state == battlePkg::Apply);
	assign StepDone = (state == battlePkg::Done);

endmodule

// File: src/battlePkg.sv
`include "battle_settings.svh"

package battlePkg;

	typedef logic [`POSITION_WIDTH-1:0] positionT;
	typedef logic [`HEALTH_WIDTH-1:0] healthT;
	typedef logic [`ATTACK_WIDTH-1:0] attackT;
	typedef logic [`DAMAGE_WIDTH-1:0] damageT;
	typedef logic [`SLOT_COUNT-1:0] slotMaskT;
	typedef logic [$clog2(`SLOT_COUNT)-1:0] slotIndexT;
	typedef logic [`SCORE_WIDTH-1:0] scoreT;

	typedef enum logic [1:0] {
		Scout,
		Tank,
		Striker,
		Guard
	} fighterKindT;

	typedef struct packed {
		logic alive;
		fighterKindT kind;
		positionT position;
		healthT health;
	} fighterT;

	typedef fighterT [`SLOT_COUNT-1:0] armyT;

	typedef struct packed {
		positionT frontPosition;
		slotIndexT frontSlot;
		logic frontValid;
		slotMaskT engaged;
	} frontT;

	typedef enum logic [2:0] {
		Idle,
		Scan,
		Total,
		Apply,
		Done
	} stepStateT;

	// Stat table, same for both armies
	function automatic healthT kindHealth(input fighterKindT kind);
		case (kind)
			Scout: return healthT'(20);
			Tank: return healthT'(40);
			Striker: return healthT'(10);
			default: return healthT'(30);
		endcase
	endfunction

	function automatic attackT kindAttack(input fighterKindT kind);
		case (kind)
			Scout: return attackT'(2);
			Tank: return attackT'(1);
			Striker: return attackT'(5);
			default: return attackT'(3);
		endcase
	endfunction

	function automatic positionT kindSpeed(input fighterKindT kind);
		case (kind)
			Scout: return positionT'(2);
			Tank: return positionT'(1);
			Striker: return positionT'(3);
			default: return positionT'(1);
		endcase
	endfunction

endpackage

// File: src/battle_settings.svh
`ifndef BATTLE_SETTINGS_SVH
`define BATTLE_SETTINGS_SVH

// Fighters per army
`define SLOT_COUNT 8

// Lane runs from 0 to FIELD_END
`define FIELD_END 320

// Contact distance between the two fronts
`define ATTACK_RANGE 8

`define POSITION_WIDTH 9
`define HEALTH_WIDTH 8
`define ATTACK_WIDTH 8

// Summed attack of one side per step
`define DAMAGE_WIDTH 12

// Kill and loss counters
`define SCORE_WIDTH 16

`endif

// File: tests/BattleTopTb.sv
`include "battle_settings.svh"

module BattleTopTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int Slots = `SLOT_COUNT;
	localparam int FieldEnd = `FIELD_END;
	localparam int Range = `ATTACK_RANGE;
	localparam int ResetCycles = 10;
	localparam int RowCount = 18;

	typedef enum logic [1:0] {
		SpawnUnitRow,
		SpawnEnemyRow,
		StepRow,
		BusyStepRow
	} actionT;

	typedef struct packed {
		actionT action;
		battlePkg::fighterKindT kind;
		int count;
	} rowT;

	// Contact comes on step 52
	// The friendly front falls 26 steps after the respawn
	rowT rows [RowCount] = '{
		'{SpawnUnitRow, battlePkg::Scout, 1},
		'{SpawnUnitRow, battlePkg::Tank, 1},
		'{SpawnUnitRow, battlePkg::Striker, 1},
		'{SpawnUnitRow, battlePkg::Guard, 1},
		'{SpawnUnitRow, battlePkg::Scout, 1},
		'{SpawnUnitRow, battlePkg::Tank, 1},
		'{SpawnUnitRow, battlePkg::Striker, 1},
		'{SpawnUnitRow, battlePkg::Guard, 1},
		'{SpawnUnitRow, battlePkg::Scout, 1},
		'{StepRow, battlePkg::Scout, 3},
		'{SpawnEnemyRow, battlePkg::Tank, 1},
		'{SpawnEnemyRow, battlePkg::Striker, 1},
		'{StepRow, battlePkg::Scout, 52},
		'{SpawnEnemyRow, battlePkg::Striker, 1},
		'{StepRow, battlePkg::Scout, 26},
		'{StepRow, battlePkg::Scout, 10},
		'{BusyStepRow, battlePkg::Scout, 1},
		'{StepRow, battlePkg::Scout, 2}
	};

	logic ClkPort = 1'b0;
	logic Reset;
	logic Tick;
	logic SpawnUnit;
	battlePkg::fighterKindT SpawnUnitKind;
	logic SpawnEnemy;
	battlePkg::fighterKindT SpawnEnemyKind;
	battlePkg::scoreT Score;
	battlePkg::scoreT UnitLosses;
	battlePkg::positionT FriendlyFront;
	battlePkg::positionT EnemyFront;
	battlePkg::slotMaskT UnitAlive;
	battlePkg::slotMaskT EnemyAlive;
	logic StepDone;

	// Side 0 of the model is friendly and side 1 is enemy
	logic fighterAlive [2][Slots];
	battlePkg::fighterKindT fighterKind [2][Slots];
	int fighterPos [2][Slots];
	int fighterHealth [2][Slots];
	int lossCount [2];
	int shownFront [2];

	int cycleCount = 0;
	int cycleLimit = ResetCycles;

	BattleTop dut (
		.ClkPort(ClkPort),
		.Reset(Reset),
		.Tick(Tick),
		.SpawnUnit(SpawnUnit),
		.SpawnUnitKind(SpawnUnitKind),
		.SpawnEnemy(SpawnEnemy),
		.SpawnEnemyKind(SpawnEnemyKind),
		.Score(Score),
		.UnitLosses(UnitLosses),
		.FriendlyFront(FriendlyFront),
		.EnemyFront(EnemyFront),
		.UnitAlive(UnitAlive),
		.EnemyAlive(EnemyAlive),
		.StepDone(StepDone)
	);

	always #4 ClkPort = ~ClkPort;

	always @(posedge ClkPort) begin
		cycleCount++;
		if (cycleCount > cycleLimit)
			abortRun("timeout: StepDone never arrived");
	end

	task automatic abortRun(input string reason);
		$display("Test failed");
		$fatal(1, "%s", reason);
	endtask

	task automatic checkMask(input string name, input battlePkg::slotMaskT expected,
			input battlePkg::slotMaskT actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %b, actual %b", name, expected, actual);
			abortRun("slot mask mismatch");
		end
	endtask

	task automatic checkPosition(input string name, input battlePkg::positionT expected,
			input battlePkg::positionT actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
			abortRun("front position mismatch");
		end
	endtask

	task automatic checkScore(input string name, input battlePkg::scoreT expected,
			input battlePkg::scoreT actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
			abortRun("counter mismatch");
		end
	endtask

	// Stat table by kind
	function automatic int statHealth(input battlePkg::fighterKindT kind);
		case (kind)
			battlePkg::Scout: return 20;
			battlePkg::Tank: return 40;
			battlePkg::Striker: return 10;
			default: return 30;
		endcase
	endfunction

	function automatic int statAttack(input battlePkg::fighterKindT kind);
		case (kind)
			battlePkg::Scout: return 2;
			battlePkg::Tank: return 1;
			battlePkg::Striker: return 5;
			default: return 3;
		endcase
	endfunction

	function automatic int statSpeed(input battlePkg::fighterKindT kind);
		case (kind)
			battlePkg::Scout: return 2;
			battlePkg::Striker: return 3;
			default: return 1;
		endcase
	endfunction

	function automatic battlePkg::slotMaskT expectedMask(input int side);
		battlePkg::slotMaskT mask;
		mask = '0;
		for (int i = 0; i < Slots; i++)
			mask[i] = fighterAlive[side][i];
		return mask;
	endfunction

	task automatic modelSpawn(input int side, input battlePkg::fighterKindT kind);
		int slot;
		slot = -1;
		for (int i = Slots - 1; i >= 0; i--)
			if (!fighterAlive[side][i])
				slot = i;
		// Full army ignores the pulse
		if (slot >= 0) begin
			fighterAlive[side][slot] = 1'b1;
			fighterKind[side][slot] = kind;
			fighterPos[side][slot] = (side == 0) ? 0 : FieldEnd;
			fighterHealth[side][slot] = statHealth(kind);
		end
	endtask

	task automatic modelStep();
		int front [2];
		int slot [2];
		logic valid [2];
		logic engaged [2][Slots];
		int total [2];
		int speed;
		for (int s = 0; s < 2; s++) begin
			valid[s] = 1'b0;
			slot[s] = 0;
			front[s] = (s == 0) ? 0 : FieldEnd;
			total[s] = 0;
			for (int i = 0; i < Slots; i++) begin
				if (fighterAlive[s][i] && (!valid[s] ||
						(s == 0 && fighterPos[s][i] > front[s]) ||
						(s == 1 && fighterPos[s][i] < front[s]))) begin
					valid[s] = 1'b1;
					front[s] = fighterPos[s][i];
					slot[s] = i;
				end
			end
		end
		for (int i = 0; i < Slots; i++) begin
			engaged[0][i] = fighterAlive[0][i] && valid[1] &&
				(front[1] - fighterPos[0][i] <= Range);
			engaged[1][i] = fighterAlive[1][i] && valid[0] &&
				(fighterPos[1][i] - front[0] <= Range);
			for (int s = 0; s < 2; s++)
				if (engaged[s][i])
					total[s] += statAttack(fighterKind[s][i]);
		end
		for (int s = 0; s < 2; s++) begin
			for (int i = 0; i < Slots; i++) begin
				speed = statSpeed(fighterKind[s][i]);
				if (fighterAlive[s][i] && !engaged[s][i] && s == 0)
					fighterPos[s][i] = (fighterPos[s][i] + speed > FieldEnd) ?
						FieldEnd : fighterPos[s][i] + speed;
				else if (fighterAlive[s][i] && !engaged[s][i])
					fighterPos[s][i] = (fighterPos[s][i] < speed) ?
						0 : fighterPos[s][i] - speed;
			end
			// Only the front slot takes the other side's total
			if (valid[s] && fighterHealth[s][slot[s]] <= total[1 - s]) begin
				fighterAlive[s][slot[s]] = 1'b0;
				lossCount[s]++;
			end else if (valid[s]) begin
				fighterHealth[s][slot[s]] -= total[1 - s];
			end
			shownFront[s] = front[s];
		end
	endtask

	task automatic verifyOutputs(input string name);
		checkMask({name, " UnitAlive"}, expectedMask(0), UnitAlive);
		checkMask({name, " EnemyAlive"}, expectedMask(1), EnemyAlive);
		checkPosition({name, " FriendlyFront"}, battlePkg::positionT'(shownFront[0]),
			FriendlyFront);
		checkPosition({name, " EnemyFront"}, battlePkg::positionT'(shownFront[1]), EnemyFront);
		checkScore({name, " Score"}, battlePkg::scoreT'(lossCount[1]), Score);
		checkScore({name, " UnitLosses"}, battlePkg::scoreT'(lossCount[0]), UnitLosses);
	endtask

	task automatic spawnFighter(input int side, input battlePkg::fighterKindT kind,
			input string name);
		SpawnUnit = (side == 0);
		SpawnEnemy = (side == 1);
		SpawnUnitKind = kind;
		SpawnEnemyKind = kind;
		@(posedge ClkPort);
		#1;
		SpawnUnit = 1'b0;
		SpawnEnemy = 1'b0;
		modelSpawn(side, kind);
		verifyOutputs(name);
	endtask

	task automatic runStep(input logic busy, input string name);
		int edges;
		edges = 0;
		Tick = 1'b1;
		while (!StepDone) begin
			@(posedge ClkPort);
			#1;
			edges++;
			// Second Tick lands while the sequencer is in Scan
			Tick = busy && (edges == 1);
		end
		if (edges != 4)
			abortRun($sformatf("%s: StepDone came %0d edges after Tick", name, edges));
		modelStep();
		verifyOutputs(name);
		repeat (busy ? 6 : 1) begin
			@(posedge ClkPort);
			#1;
			if (StepDone)
				abortRun({name, ": StepDone stayed high or a second step started"});
		end
	endtask

	initial begin
		string name;
		actionT act;
		Reset = 1'b1;
		Tick = 1'b0;
		SpawnUnit = 1'b0;
		SpawnUnitKind = battlePkg::Scout;
		SpawnEnemy = 1'b0;
		SpawnEnemyKind = battlePkg::Scout;
		for (int s = 0; s < 2; s++) begin
			for (int i = 0; i < Slots; i++)
				fighterAlive[s][i] = 1'b0;
			lossCount[s] = 0;
		end
		shownFront[0] = 0;
		shownFront[1] = FieldEnd;
		foreach (rows[r])
			cycleLimit += 16 * rows[r].count;
		repeat (ResetCycles) @(posedge ClkPort);
		#1;
		Reset = 1'b0;
		if (StepDone !== 1'b0)
			abortRun("StepDone is high right after reset");
		verifyOutputs("after reset");
		foreach (rows[r]) begin
			act = rows[r].action;
			for (int n = 0; n < rows[r].count; n++) begin
				name = $sformatf("row %0d %s pass %0d", r, act.name(), n);
				case (act)
					SpawnUnitRow: spawnFighter(0, rows[r].kind, name);
					SpawnEnemyRow: spawnFighter(1, rows[r].kind, name);
					StepRow: runStep(1'b0, name);
					default: runStep(1'b1, name);
				endcase
			end
		end
		$display("Test passed");
		$finish;
	end

endmodule
